//--- bench/uart_rx_checker.sv
// status rules for uart_rx; bound to every uart_rx instance, checks sampled on clk rising edge
`timescale 1ns/1ps

module uart_rx_checker (
  input logic                    clk,
  input logic                    aresetn,
  input logic                    read_byte,
  input logic                    frame_valid,   // internal strobe of the frame stage
  input uart_rx_pkg::rx_status_t status
);

  // ------------------------------
  // holding register rules
  // ------------------------------
  // a dropped frame always leaves a byte waiting
  overflow_needs_full: assert property (
    @(posedge clk) disable iff (!aresetn) status.overflow |-> status.full
  ) else $error("overflow is set while full is clear");

  // a frame in the same cycle refills the register, so it is excluded
  read_empties: assert property (
    @(posedge clk) disable iff (!aresetn) (read_byte && !frame_valid) |=> !status.full
  ) else $error("full still set one cycle after read_byte");

  reset_quiet: assert property (
    @(posedge clk) !aresetn |-> (status == '0)   // all flags low in reset
  ) else $error("status is not zero while reset is asserted");

endmodule

bind uart_rx uart_rx_checker u_checker (
  .clk         (clk),
  .aresetn     (aresetn),
  .read_byte   (read_byte),
  .frame_valid (frame_valid),
  .status      (status)
);

//--- bench/uart_rx_tb.sv
// random-frame testbench for uart_rx; baud tick every 4 clocks, frames checked after one idle bit
`timescale 1ns/1ps

module uart_rx_tb;

  import uart_rx_pkg::*;

  localparam int num_frames  = 200;
  localparam int bit_clocks  = 4 * oversample;                         // 64 clocks per bit
  localparam int watchdog_ns = num_frames * 12 * bit_clocks * 8 + 20000;

  logic              clk;
  logic              aresetn;
  logic              baud_tick;
  rx_cfg_t           cfg;
  logic              rx;
  logic              read_byte;
  logic              clear_parity;
  logic              clear_framing;
  logic [data_w-1:0] rx_byte;
  rx_status_t        status;

  // reference model state
  logic [data_w-1:0] exp_byte;
  rx_status_t        exp_status;
  logic [31:0]       lcg_state = 32'hed5c_9e06;

  uart_rx DUT (
    .clk           (clk),
    .aresetn       (aresetn),
    .baud_tick     (baud_tick),
    .cfg           (cfg),
    .rx            (rx),
    .read_byte     (read_byte),
    .clear_parity  (clear_parity),
    .clear_framing (clear_framing),
    .rx_byte       (rx_byte),
    .status        (status)
  );

  // ------------------------------
  // clock, baud tick, watchdog
  // ------------------------------
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // one-cycle strobe every fourth clock
  initial
  begin
    baud_tick = 1'b0;
    forever
    begin
      repeat (3) @(negedge clk);
      baud_tick = 1'b1;
      @(negedge clk);
      baud_tick = 1'b0;
    end
  end

  initial
  begin
    #(watchdog_ns);
    $display("timeout: the frame sequence did not finish in %0d ns", watchdog_ns);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // one bit time with an optional single inverted tick at offset off
  task automatic send_bit(input logic b, input logic glitch, input int off);
    int t;
    for (t = 0; t < oversample; t++)
    begin
      rx = (glitch && (t == off)) ? ~b : b;
      repeat (4) @(negedge clk);
    end
  endtask

  task automatic send_frame(input rx_cfg_t c, input logic [7:0] d, input logic bad_par,
                            input logic bad_stop, input logic glitch, input int gbit,
                            input int goff);
    int   nbits;
    int   i;
    logic par;
    nbits = c.bit8 ? 8 : 7;
    par   = c.odd_n_even;        // odd parity starts from one
    send_bit(1'b0, 1'b0, 0);     // start bit
    for (i = 0; i < nbits; i++)
    begin
      send_bit(d[i], glitch && (i == gbit), goff);
      par = par ^ d[i];
    end
    if (c.parity_en)
    begin
      send_bit(par ^ bad_par, 1'b0, 0);
    end
    send_bit(~bad_stop, 1'b0, 0);
  endtask

  task automatic update_model(input rx_cfg_t c, input logic [7:0] d, input logic bad_par,
                              input logic bad_stop);
    if (exp_status.full)
    begin
      exp_status.overflow = 1'b1;   // new data dropped
    end
    else
    begin
      exp_byte        = c.bit8 ? d : {1'b0, d[6:0]};
      exp_status.full = 1'b1;
    end
    if (c.parity_en && bad_par)
    begin
      exp_status.parity_err = 1'b1;
    end
    if (bad_stop)
    begin
      exp_status.framing_err = 1'b1;
    end
  endtask

  task automatic apply_pulses(input logic rd, input logic clr_p, input logic clr_f);
    read_byte     = rd;
    clear_parity  = clr_p;
    clear_framing = clr_f;
    @(negedge clk);
    read_byte     = 1'b0;
    clear_parity  = 1'b0;
    clear_framing = 1'b0;
    if (rd)
    begin
      exp_status.full     = 1'b0;
      exp_status.overflow = 1'b0;
    end
    if (clr_p)
    begin
      exp_status.parity_err = 1'b0;
    end
    if (clr_f)
    begin
      exp_status.framing_err = 1'b0;
    end
  endtask

  // ------------------------------
  // stimulus and checks
  // ------------------------------
  initial
  begin : stimulus
    logic [31:0] r;
    logic [7:0]  data_r;
    rx_cfg_t     cfg_r;
    logic        bad_par;
    logic        bad_stop;
    logic        glitch;
    int          gbit;
    int          goff;
    int          n;
    aresetn       = 1'b0;
    cfg           = '0;
    rx            = 1'b1;    // idle line
    read_byte     = 1'b0;
    clear_parity  = 1'b0;
    clear_framing = 1'b0;
    exp_byte      = '0;
    exp_status    = '0;
    repeat (16) @(negedge clk);
    aresetn = 1'b1;
    repeat (4) @(negedge clk);
    check_value("rx_byte after reset", {24'd0, rx_byte}, {24'd0, exp_byte});
    check_value("status after reset", {28'd0, status}, {28'd0, exp_status});

    for (n = 0; n < num_frames; n++)
    begin
      r        = next_rand();
      data_r   = r[31:24];
      cfg_r    = rx_cfg_t'(r[23:21]);
      bad_par  = (r[20:18] == 3'd0);
      bad_stop = (r[17:15] == 3'd0);
      glitch   = (r[14:13] == 2'd0);
      gbit     = int'(r[12:10]);
      goff     = 2 + int'(r[8:6]);   // spike stays clear of the bit edges
      if (!cfg_r.bit8 && (gbit == 7))
      begin
        gbit = 6;
      end

      cfg = cfg_r;
      send_frame(cfg_r, data_r, bad_par, bad_stop, glitch, gbit, goff);
      r = next_rand();
      send_bit(1'b1, (r[25:24] == 2'd0), 6);   // idle bit that sometimes carries a low spike
      update_model(cfg_r, data_r, bad_par, bad_stop);
      check_value("rx_byte after frame", {24'd0, rx_byte}, {24'd0, exp_byte});
      check_value("status after frame", {28'd0, status}, {28'd0, exp_status});

      apply_pulses(r[31:30] != 2'd0, r[29:28] == 2'd0, r[27:26] == 2'd0);
      check_value("rx_byte after pulses", {24'd0, rx_byte}, {24'd0, exp_byte});
      check_value("status after pulses", {28'd0, status}, {28'd0, exp_status});
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- hdl/rx_frame_fsm.sv
// frame receiver; cfg is taken at start acceptance and must stay static until the stop bit
`timescale 1ns/1ps

module rx_frame_fsm (
  input  logic                  clk,
  input  logic                  aresetn,
  input  logic                  baud_tick,     // 16x bit rate strobe
  input  logic                  line_filt,     // glitch-filtered line
  input  uart_rx_pkg::rx_cfg_t  cfg,
  output logic                  frame_valid,   // one cycle, on the stop check tick
  output uart_rx_pkg::rx_frame_t frame
);

  import uart_rx_pkg::*;

  rx_state_e             state_q;
  logic [tick_cnt_w-1:0] tick_cnt;    // position inside the current bit time
  logic [3:0]            bit_cnt;     // bits taken so far, parity included
  logic [3:0]            last_bit;    // total bits in this frame
  rx_cfg_t               cfg_q;       // cfg of the frame in flight
  logic [data_w:0]       shift_q;     // data lands LSB aligned, parity on top
  logic                  par_acc;     // running xor of the data bits
  logic                  par_err_q;
  logic                  start_ok;
  logic                  sample_now;
  logic                  parity_bit;

  // start bit still low at mid bit
  assign start_ok   = baud_tick && (state_q == idle) && (tick_cnt == start_mid);
  assign sample_now = baud_tick && (state_q == data_bits) && (tick_cnt == sample_point);
  assign parity_bit = cfg_q.parity_en && (bit_cnt == last_bit - 4'd1);

  // ------------------------------
  // bit-time counter
  // ------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      tick_cnt <= '0;
    end
    else if (baud_tick)
    begin
      // hunting for a start, any high sample restarts the count
      if ((state_q == idle) && (line_filt || (tick_cnt == start_mid)))
      begin
        tick_cnt <= '0;
      end
      else if ((state_q == wait_state) && (tick_cnt == wait_limit))
      begin
        tick_cnt <= '0;
      end
      else
      begin
        tick_cnt <= tick_cnt + 1'b1;   // wraps at the end of each bit time
      end
    end
  end

  // ------------------------------
  // frame state machine
  // ------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state_q  <= idle;
      cfg_q    <= '0;
      last_bit <= 4'd9;
    end
    else if (baud_tick)
    begin
      case (state_q)
        idle:
        begin
          if (tick_cnt == start_mid)
          begin
            state_q <= data_bits;
            cfg_q   <= cfg;
            case ({cfg.bit8, cfg.parity_en})
              2'b00:   last_bit <= 4'd7;
              2'b11:   last_bit <= 4'd9;
              default: last_bit <= 4'd8;
            endcase
          end
        end
        data_bits:
        begin
          if (bit_cnt == last_bit)
          begin
            state_q <= stop_bit;    // tick after the last sample
          end
        end
        stop_bit:
        begin
          if (tick_cnt == sample_point)
          begin
            state_q <= wait_state;
          end
        end
        wait_state:
        begin
          // line back high, or give up and hunt again
          if (line_filt || (tick_cnt == wait_limit))
          begin
            state_q <= idle;
          end
        end
        default:
        begin
          state_q <= idle;
        end
      endcase
    end
  end

  // ------------------------------
  // shift register and bit count
  // ------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      bit_cnt <= '0;
    end
    else if (start_ok)
    begin
      bit_cnt <= '0;
    end
    else if (sample_now)
    begin
      bit_cnt <= bit_cnt + 4'd1;
    end
  end

  // insert point depends on frame length, lsb arrives first
  always_ff @(posedge clk)
  begin
    if (start_ok)
    begin
      shift_q <= '0;
    end
    else if (sample_now)
    begin
      case ({cfg_q.bit8, cfg_q.parity_en})
        2'b00:   shift_q[6:0] <= {line_filt, shift_q[6:1]};
        2'b11:   shift_q[8:0] <= {line_filt, shift_q[8:1]};
        default: shift_q[7:0] <= {line_filt, shift_q[7:1]};
      endcase
    end
  end

  // ------------------------------
  // parity
  // ------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      par_acc   <= 1'b0;
      par_err_q <= 1'b0;
    end
    else if (start_ok)
    begin
      par_acc   <= 1'b0;
      par_err_q <= 1'b0;
    end
    else if (sample_now)
    begin
      if (parity_bit)
      begin
        // even parity wants total xor 0, odd wants 1
        par_err_q <= par_acc ^ line_filt ^ cfg_q.odd_n_even;
      end
      else
      begin
        par_acc <= par_acc ^ line_filt;
      end
    end
  end

  // ------------------------------
  // frame record
  // ------------------------------
  assign frame_valid = baud_tick && (state_q == stop_bit) && (tick_cnt == stop_check);

  assign frame = '{
    data:        {cfg_q.bit8 & shift_q[data_w-1], shift_q[data_w-2:0]},
    parity_err:  par_err_q,
    framing_err: ~line_filt    // stop bit must be high
  };

endmodule

//--- hdl/rx_sample_filter.sv
// majority glitch filter on the raw line; samples only on baud_tick, so delay is 2 to 3 ticks
`timescale 1ns/1ps

module rx_sample_filter (
  input  logic clk,
  input  logic aresetn,
  input  logic baud_tick,   // 16x bit rate strobe
  input  logic rx,          // raw serial line
  output logic line_filt    // filtered line level
);

  logic [2:0] samples;      // [2] is the newest sample

  // ------------------------------
  // sample shift register
  // ------------------------------
  // preset to ones so a line held low across reset release is not a start
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      samples <= 3'b111;
    end
    else if (baud_tick)
    begin
      samples <= {rx, samples[2:1]};
    end
  end

  // ------------------------------
  // majority voter
  // ------------------------------
  // two of three samples decide, so a single-tick spike is dropped
  always_comb
  begin
    case (samples)
      3'b000:  line_filt = 1'b0;
      3'b001:  line_filt = 1'b0;
      3'b010:  line_filt = 1'b0;
      3'b100:  line_filt = 1'b0;
      3'b011:  line_filt = 1'b1;
      3'b101:  line_filt = 1'b1;
      3'b110:  line_filt = 1'b1;
      default: line_filt = 1'b1;   // 3'b111
    endcase
  end

endmodule

//--- hdl/rx_status_regs.sv
// receive holding register and sticky flags; no queue, a frame that arrives while full is lost
`timescale 1ns/1ps

module rx_status_regs (
  input  logic                            clk,
  input  logic                            aresetn,
  input  logic                            frame_valid,
  input  uart_rx_pkg::rx_frame_t          frame,
  input  logic                            read_byte,      // byte taken, clears full and overflow
  input  logic                            clear_parity,
  input  logic                            clear_framing,
  output logic [uart_rx_pkg::data_w-1:0]  rx_byte,
  output uart_rx_pkg::rx_status_t         status
);

  // ------------------------------
  // holding register
  // ------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_byte <= '0;
    end
    else if (frame_valid && !status.full)
    begin
      rx_byte <= frame.data;   // old byte kept while full
    end
  end

  // ------------------------------
  // full and overflow
  // ------------------------------
  // a frame in the same cycle as a read keeps full set
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      status.full     <= 1'b0;
      status.overflow <= 1'b0;
    end
    else
    begin
      if (frame_valid)
      begin
        status.full <= 1'b1;
      end
      else if (read_byte)
      begin
        status.full <= 1'b0;
      end

      if (frame_valid && status.full)
      begin
        status.overflow <= 1'b1;
      end
      else if (read_byte)
      begin
        status.overflow <= 1'b0;
      end
    end
  end

  // ------------------------------
  // error flags
  // ------------------------------
  // set from every frame, even one dropped for overflow
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      status.parity_err  <= 1'b0;
      status.framing_err <= 1'b0;
    end
    else
    begin
      if (frame_valid && frame.parity_err)
      begin
        status.parity_err <= 1'b1;     // new error beats the clear
      end
      else if (clear_parity)
      begin
        status.parity_err <= 1'b0;
      end

      if (frame_valid && frame.framing_err)
      begin
        status.framing_err <= 1'b1;
      end
      else if (clear_framing)
      begin
        status.framing_err <= 1'b0;
      end
    end
  end

endmodule

//--- hdl/uart_rx.sv
// UART receiver top; baud_tick is a one-cycle strobe at 16x the bit rate, no handshake on outputs
`timescale 1ns/1ps

module uart_rx (
  input  logic                            clk,
  input  logic                            aresetn,
  input  logic                            baud_tick,
  input  uart_rx_pkg::rx_cfg_t            cfg,
  input  logic                            rx,
  input  logic                            read_byte,
  input  logic                            clear_parity,
  input  logic                            clear_framing,
  output logic [uart_rx_pkg::data_w-1:0]  rx_byte,
  output uart_rx_pkg::rx_status_t         status
);

  import uart_rx_pkg::*;

  logic      line_filt;
  logic      frame_valid;
  rx_frame_t frame;

  // ------------------------------
  // line filter
  // ------------------------------
  rx_sample_filter u_filter (
    .clk       (clk),
    .aresetn   (aresetn),
    .baud_tick (baud_tick),
    .rx        (rx),
    .line_filt (line_filt)
  );

  // ------------------------------
  // frame receiver
  // ------------------------------
  rx_frame_fsm u_frame (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .line_filt   (line_filt),
    .cfg         (cfg),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  // status lands one cycle after frame_valid
  rx_status_regs u_status (
    .clk           (clk),
    .aresetn       (aresetn),
    .frame_valid   (frame_valid),
    .frame         (frame),
    .read_byte     (read_byte),
    .clear_parity  (clear_parity),
    .clear_framing (clear_framing),
    .rx_byte       (rx_byte),
    .status        (status)
  );

endmodule

//--- hdl/uart_rx_pkg.sv
// shared UART receiver constants and types; oversampling is fixed at 16 ticks per bit

package uart_rx_pkg;

  // ------------------------------
  // oversampling and count points
  // ------------------------------
  localparam int oversample = 16;                    // baud ticks per bit
  localparam int tick_cnt_w = $clog2(oversample);    // bit-time counter width

  // counter values inside one bit time
  localparam logic [tick_cnt_w-1:0] start_mid    = tick_cnt_w'(8);   // start still low here
  localparam logic [tick_cnt_w-1:0] stop_check   = tick_cnt_w'(14);  // stop bit checked
  localparam logic [tick_cnt_w-1:0] sample_point = tick_cnt_w'(15);  // data/parity taken
  localparam logic [tick_cnt_w-1:0] wait_limit   = tick_cnt_w'(6);   // forced return to idle

  localparam int data_w = 8;                         // widest character

  // ------------------------------
  // configuration and state
  // ------------------------------
  typedef struct packed {
    logic bit8;          // 8 data bits, else 7
    logic parity_en;     // parity bit follows the data
    logic odd_n_even;    // odd parity, else even
  } rx_cfg_t;

  typedef enum logic [1:0] {
    idle,
    data_bits,
    stop_bit,
    wait_state
  } rx_state_e;

  // ------------------------------
  // records between stages
  // ------------------------------
  // one received character, top data bit is 0 in 7-bit mode
  typedef struct packed {
    logic [data_w-1:0] data;
    logic              parity_err;
    logic              framing_err;
  } rx_frame_t;

  typedef struct packed {
    logic full;          // byte waiting to be read
    logic overflow;      // a frame was dropped while full
    logic parity_err;    // sticky until cleared
    logic framing_err;   // sticky until cleared
  } rx_status_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the uart_rx testbench with Verilator and runs it.
# The result comes from the log: the fail message, or a missing pass message, means failure.

cd "$(dirname "$0")" || exit 1

log_file=sim.log
rm -f "$log_file"

verilator --binary --timing --assert \
  --top-module uart_rx_tb \
  -f uart_rx.f \
  -o uart_rx_sim \
  > "$log_file" 2>&1 \
  && ./obj_dir/uart_rx_sim >> "$log_file" 2>&1 \
  || echo "build or simulation returned a failing status" >> "$log_file"

cat "$log_file"

grep -q "ERRORS FOUND" "$log_file" && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" "$log_file" && { echo "simulation passed"; exit 0; } \
  || { echo "simulation did not complete"; exit 1; }

//--- uart_rx.f
hdl/uart_rx_pkg.sv
hdl/rx_sample_filter.sv
hdl/rx_frame_fsm.sv
hdl/rx_status_regs.sv
hdl/uart_rx.sv
bench/uart_rx_checker.sv
bench/uart_rx_tb.sv
